// File: lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths fixed by the instruction set
  ////////////////////////////////////////////////////////////////////////////

  // Byte address on the data bus
  typedef logic [31:0] addr_t;

  // Data word, used for operands, write data and read data
  typedef logic [31:0] word_t;

  // One enable bit per byte lane of a word
  typedef logic [3:0] be_t;

  // Byte position of an address inside its word
  typedef logic [1:0] offset_t;

  ////////////////////////////////////////////////////////////////////////////
  // Access size
  ////////////////////////////////////////////////////////////////////////////

  // Encoding follows the funct3 size field of loads and stores
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline depth
  ////////////////////////////////////////////////////////////////////////////

  // Default limit of outstanding bus transfers
  // Two covers both halves of a split access
  parameter int LSU_DEPTH = 2;

endpackage

// File: lsu_addr_stage.sv
`timescale 1ns/10ps

module lsu_addr_stage (
  input  logic              clk,
  input  logic              rst_n,
  // Producer side
  input  logic              valid_i,
  input  logic              we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  lsu_pkg::word_t    operand_a_i,
  input  lsu_pkg::word_t    operand_b_i,
  input  lsu_pkg::word_t    wdata_i,
  // Granted address phase, from the tracker
  input  logic              accept_i,
  // Request fields
  output lsu_pkg::addr_t    addr_o,
  output lsu_pkg::be_t      be_o,
  output lsu_pkg::word_t    wdata_o,
  output logic              we_o,
  // Access needs a second transfer
  output logic              split_o,
  // Metadata for the response stage
  output lsu_pkg::lsu_size_e size_o,
  output lsu_pkg::offset_t  offset_o
);

  import lsu_pkg::*;

  addr_t   eff_addr;
  addr_t   next_word_addr;
  offset_t offset;
  logic    split_q;
  logic    [63:0] wdata_dbl;

  // Effective address, base plus displacement
  assign eff_addr = operand_a_i + operand_b_i;
  assign offset   = eff_addr[1:0];

  // Word after the one holding the first byte
  assign next_word_addr = {eff_addr[31:2] + 30'd1, 2'b00};

  ////////////////////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////////////////////

  // Word at nonzero offset, or halfword in the top byte lane
  // Never raised once the second phase is running
  always_comb begin
    split_o = 1'b0;
    if (valid_i && !split_q) begin
      case (size_i)
        SIZE_WORD: split_o = (offset != 2'b00);
        SIZE_HALF: split_o = (offset == 2'b11);
        default:   split_o = 1'b0;
      endcase
    end
  end

  // Second phase marker
  // Cleared between instructions so a dropped access cannot leave it set
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q <= 1'b0;
    end else if (!valid_i) begin
      split_q <= 1'b0;
    end else if (accept_i) begin
      split_q <= split_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    be_o = 4'b0000;
    case (size_i)
      SIZE_BYTE: begin
        be_o = be_t'(4'b0001 << offset);
      end
      SIZE_HALF: begin
        if (split_q) begin
          // Upper byte lands in lane 0 of the next word
          be_o = 4'b0001;
        end else if (offset == 2'b11) begin
          be_o = 4'b1000;
        end else begin
          be_o = be_t'(4'b0011 << offset);
        end
      end
      default: begin
        if (split_q) begin
          // Remaining low lanes of the next word
          case (offset)
            2'b01:   be_o = 4'b0001;
            2'b10:   be_o = 4'b0011;
            2'b11:   be_o = 4'b0111;
            default: be_o = 4'b0000;
          endcase
        end else begin
          be_o = be_t'(4'b1111 << offset);
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write data and address
  ////////////////////////////////////////////////////////////////////////////

  // Rotate left by the byte offset
  // Low bytes go to the first word, the wrapped bytes to the second
  assign wdata_dbl = {wdata_i, wdata_i} << {offset, 3'b000};
  assign wdata_o   = wdata_dbl[63:32];

  // First phase keeps the byte address, second goes word aligned
  assign addr_o = split_q ? next_word_addr : eff_addr;
  assign we_o   = we_i;

  // Response stage needs size and offset for realignment
  assign size_o   = size_i;
  assign offset_o = offset;

endmodule

// File: lsu_txn_tracker.sv
`timescale 1ns/10ps

module lsu_txn_tracker #(
  parameter int DEPTH = lsu_pkg::LSU_DEPTH
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  // Current phase is the first of a split access
  input  logic split_i,
  // Bus handshake
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  output logic data_req_o,
  // Granted address phase
  output logic accept_o,
  // Producer may move on
  output logic ready_o,
  output logic busy_o
);

  // Wide enough for DEPTH up to three
  typedef logic [1:0] cnt_t;

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic resp_free;
  logic below_limit;

  ////////////////////////////////////////////////////////////////////////////
  // Request gating
  ////////////////////////////////////////////////////////////////////////////

  // Lock-step with the response stage
  // Free when empty, or when its pending response returns now
  assign resp_free = (cnt_q == 2'd0) || data_rvalid_i;

  // Outstanding limit
  assign below_limit = int'(cnt_q) < DEPTH;

  // Combinational path from rvalid to req
  assign data_req_o = valid_i && resp_free && below_limit;
  assign accept_o   = data_req_o && data_gnt_i;

  // First half of a split does not release the producer
  assign ready_o = accept_o && !split_i;

  assign busy_o = (cnt_q != 2'd0) || data_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // Outstanding transfer count
  ////////////////////////////////////////////////////////////////////////////

  // Up on grant and down on response with no change when both coincide
  always_comb begin
    case ({accept_o, data_rvalid_i})
      2'b10:   cnt_d = cnt_q + 2'd1;
      2'b01:   cnt_d = cnt_q - 2'd1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

endmodule

// File: lsu_resp_stage.sv
`timescale 1ns/10ps

module lsu_resp_stage (
  input  logic              clk,
  input  logic              rst_n,
  // Granted address phase and its metadata
  input  logic              accept_i,
  input  logic              split_i,
  input  logic              we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic              sext_i,
  input  lsu_pkg::offset_t  offset_i,
  // Bus response
  input  logic              data_rvalid_i,
  input  lsu_pkg::word_t    data_rdata_i,
  // Result towards the core
  output logic              result_valid_o,
  output lsu_pkg::word_t    result_rdata_o
);

  import lsu_pkg::*;

  lsu_size_e size_q;
  logic      sext_q;
  logic      we_q;
  offset_t   offset_q;
  // Low only while the first half of a split is in flight
  logic      last_q;

  word_t       rdata_q;
  word_t       rdata_ext;
  logic        rdata_is_split;
  logic [63:0] rdata_full;
  logic [63:0] rdata_aligned;

  ////////////////////////////////////////////////////////////////////////////
  // Access metadata
  ////////////////////////////////////////////////////////////////////////////

  // Loaded on every granted phase
  // With lock-step only one transfer is ever waiting here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      size_q   <= SIZE_BYTE;
      sext_q   <= 1'b0;
      we_q     <= 1'b0;
      offset_q <= 2'b00;
      last_q   <= 1'b0;
    end else if (accept_i) begin
      size_q   <= size_i;
      sext_q   <= sext_i;
      we_q     <= we_i;
      offset_q <= offset_i;
      last_q   <= !split_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Realignment
  ////////////////////////////////////////////////////////////////////////////

  // Data spread over two bus words
  assign rdata_is_split = ((size_q == SIZE_WORD) && (offset_q != 2'b00)) ||
                          ((size_q == SIZE_HALF) && (offset_q == 2'b11));

  // Previous half below the new word when split
  // Otherwise the word twice, so the shift wraps the lanes
  assign rdata_full = rdata_is_split ? {data_rdata_i, rdata_q} :
                                       {data_rdata_i, data_rdata_i};

  assign rdata_aligned = rdata_full >> {offset_q, 3'b000};

  // Zero or sign extension to the access size
  always_comb begin
    case (size_q)
      SIZE_BYTE: rdata_ext = {{24{sext_q && rdata_aligned[7]}}, rdata_aligned[7:0]};
      SIZE_HALF: rdata_ext = {{16{sext_q && rdata_aligned[15]}}, rdata_aligned[15:0]};
      default:   rdata_ext = rdata_aligned[31:0];
    endcase
  end

  // First half kept raw for the next response
  // Completed loads keep the extended value
  always_ff @(posedge clk) begin
    if (data_rvalid_i && !we_q) begin
      if (!last_q) begin
        rdata_q <= data_rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  // One pulse per access, on its last response
  assign result_valid_o = data_rvalid_i && last_q;
  assign result_rdata_o = rdata_ext;

endmodule

// File: lsu_top.sv
`timescale 1ns/10ps

module lsu_top #(
  parameter int DEPTH = lsu_pkg::LSU_DEPTH
) (
  input  logic              clk,
  input  logic              rst_n,
  // Producer side
  input  logic              valid_i,
  input  logic              we_i,
  input  lsu_pkg::lsu_size_e size_i,
  input  logic              sext_i,
  input  lsu_pkg::word_t    operand_a_i,
  input  lsu_pkg::word_t    operand_b_i,
  input  lsu_pkg::word_t    wdata_i,
  output logic              ready_o,
  output logic              busy_o,
  // Data bus
  output logic              data_req_o,
  input  logic              data_gnt_i,
  output lsu_pkg::addr_t    data_addr_o,
  output logic              data_we_o,
  output lsu_pkg::be_t      data_be_o,
  output lsu_pkg::word_t    data_wdata_o,
  input  logic              data_rvalid_i,
  input  lsu_pkg::word_t    data_rdata_i,
  // Result
  output logic              result_valid_o,
  output lsu_pkg::word_t    result_rdata_o
);

  import lsu_pkg::*;

  logic      split;
  logic      accept;
  lsu_size_e acc_size;
  offset_t   acc_offset;

  // Address phase, drives the bus fields directly
  lsu_addr_stage u_addr (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid_i),
    .we_i        (we_i),
    .size_i      (size_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .wdata_i     (wdata_i),
    .accept_i    (accept),
    .addr_o      (data_addr_o),
    .be_o        (data_be_o),
    .wdata_o     (data_wdata_o),
    .we_o        (data_we_o),
    .split_o     (split),
    .size_o      (acc_size),
    .offset_o    (acc_offset)
  );

  // Request gating and outstanding count
  lsu_txn_tracker #(
    .DEPTH (DEPTH)
  ) u_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .split_i       (split),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .accept_o      (accept),
    .ready_o       (ready_o),
    .busy_o        (busy_o)
  );

  // Response side, fed straight from the bus
  lsu_resp_stage u_resp (
    .clk            (clk),
    .rst_n          (rst_n),
    .accept_i       (accept),
    .split_i        (split),
    .we_i           (data_we_o),
    .size_i         (acc_size),
    .sext_i         (sext_i),
    .offset_i       (acc_offset),
    .data_rvalid_i  (data_rvalid_i),
    .data_rdata_i   (data_rdata_i),
    .result_valid_o (result_valid_o),
    .result_rdata_o (result_rdata_o)
  );

endmodule

// File: tb_lsu_assertions.sv
`timescale 1ns/10ps

module tb_lsu_assertions #(
  parameter int DEPTH = lsu_pkg::LSU_DEPTH
) (
  input logic           clk,
  input logic           rst_n,
  // Data bus, as seen at the LSU boundary
  input logic           req_i,
  input logic           gnt_i,
  input lsu_pkg::addr_t addr_i,
  input logic           we_i,
  input lsu_pkg::be_t   be_i,
  input lsu_pkg::word_t wdata_i,
  input logic           rvalid_i,
  input logic           result_valid_i,
  // Outstanding transfer count inside the tracker
  input logic [1:0]     cnt_i
);

  // Address phase holds until the memory grants it
  req_fields_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_i && !gnt_i) |=>
      (req_i && $stable(addr_i) && $stable(we_i) && $stable(be_i) && $stable(wdata_i))
  ) else $error("Bus request dropped or changed before its grant");

  count_limit: assert property (
    @(posedge clk) disable iff (!rst_n) int'(cnt_i) <= DEPTH
  ) else $error("Outstanding transfer count above the depth limit");

  // Results only ever come with a bus response
  result_with_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n) result_valid_i |-> rvalid_i
  ) else $error("result_valid_o high without data_rvalid_i");

  req_low_in_reset: assert property (
    @(posedge clk) !rst_n |-> !req_i
  ) else $error("data_req_o high during reset");

endmodule

bind lsu_top tb_lsu_assertions #(
  .DEPTH (DEPTH)
) u_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .req_i          (data_req_o),
  .gnt_i          (data_gnt_i),
  .addr_i         (data_addr_o),
  .we_i           (data_we_o),
  .be_i           (data_be_o),
  .wdata_i        (data_wdata_o),
  .rvalid_i       (data_rvalid_i),
  .result_valid_i (result_valid_o),
  .cnt_i          (u_tracker.cnt_q)
);

// File: tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;

  import lsu_pkg::*;

  localparam int NUM_TESTS  = 31;
  localparam int WAIT_LIMIT = 20;

  // One access with the load value worked out by hand
  typedef struct {
    logic      we;
    lsu_size_e size;
    logic      sext;
    word_t     op_a;
    word_t     op_b;
    word_t     wdata;
    word_t     exp;
  } entry_t;

  logic      clk;
  logic      rst_n;
  logic      valid_i;
  logic      we_i;
  lsu_size_e size_i;
  logic      sext_i;
  word_t     operand_a_i;
  word_t     operand_b_i;
  word_t     wdata_i;
  logic      ready_o;
  logic      busy_o;
  logic      data_req_o;
  logic      data_gnt_i;
  addr_t     data_addr_o;
  logic      data_we_o;
  be_t       data_be_o;
  word_t     data_wdata_o;
  logic      data_rvalid_i;
  word_t     data_rdata_i;
  logic      result_valid_o;
  word_t     result_rdata_o;

  entry_t tbl [NUM_TESTS];
  int     n_entries;
  int     errors;
  int     failed_tests;

  // Memory model state
  word_t  mem [64];
  word_t  rsp_data_q [$];
  int     rsp_due_q [$];
  addr_t  grant_addr_q [$];
  be_t    grant_be_q [$];
  int     cyc;
  int     gnt_wait;
  int     pulses;

  lsu_top #(
    .DEPTH (LSU_DEPTH)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic add_entry(input logic we, input lsu_size_e size, input logic sext,
                           input word_t a, input word_t b, input word_t wd, input word_t exp);
    tbl[n_entries] = '{we, size, sext, a, b, wd, exp};
    n_entries++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic fill_table();
    // Aligned words and their read back
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'h0, 32'h1122_3344, 32'h0);
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h10, 32'h4, 32'h8899_aabb, 32'h0);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0, 32'h0, 32'h1122_3344);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h0, 32'h0, 32'h8899_aabb);
    // Bytes at every lane with sign and zero extension
    add_entry(1'b0, SIZE_BYTE, 1'b1, 32'h14, 32'h0, 32'h0, 32'hffff_ffbb);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h14, 32'h1, 32'h0, 32'h0000_00aa);
    add_entry(1'b0, SIZE_BYTE, 1'b1, 32'h14, 32'h2, 32'h0, 32'hffff_ff99);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h14, 32'h3, 32'h0, 32'h0000_0088);
    // Halfwords at offsets 0, 1 and 2
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h14, 32'h0, 32'h0, 32'hffff_aabb);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h14, 32'h1, 32'h0, 32'h0000_99aa);
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h14, 32'h2, 32'h0, 32'hffff_8899);
    // Partial stores keep the neighbour bytes
    add_entry(1'b1, SIZE_BYTE, 1'b0, 32'h10, 32'h2, 32'h0000_00ee, 32'h0);
    add_entry(1'b1, SIZE_HALF, 1'b0, 32'h14, 32'h1, 32'h0000_c3d2, 32'h0);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h0, 32'h0, 32'h11ee_3344);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h14, 32'h0, 32'h0, 32'h88c3_d2bb);
    // Loads across the 0x14 word boundary
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h10, 32'h3, 32'h0, 32'hffff_bb11);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h1, 32'h0, 32'hbb11_ee33);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h2, 32'h0, 32'hd2bb_11ee);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h10, 32'h3, 32'h0, 32'hc3d2_bb11);
    // Split stores read back split and by lane
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h18, 32'h2, 32'hcafe_f00d, 32'h0);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h18, 32'h2, 32'h0, 32'hcafe_f00d);
    add_entry(1'b1, SIZE_HALF, 1'b0, 32'h1c, 32'h3, 32'h0000_5a6b, 32'h0);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h1c, 32'h3, 32'h0, 32'h0000_5a6b);
    add_entry(1'b0, SIZE_BYTE, 1'b1, 32'h1c, 32'h0, 32'h0, 32'hffff_fffe);
    add_entry(1'b0, SIZE_BYTE, 1'b0, 32'h1c, 32'h1, 32'h0, 32'h0000_00ca);
    add_entry(1'b1, SIZE_WORD, 1'b0, 32'h20, 32'h1, 32'h0123_4567, 32'h0);
    add_entry(1'b0, SIZE_HALF, 1'b0, 32'h1c, 32'h3, 32'h0, 32'h0000_5a6b);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h1, 32'h0, 32'h0123_4567);
    add_entry(1'b0, SIZE_WORD, 1'b0, 32'h20, 32'h0, 32'h0, 32'h2345_675a);
    // Negative displacement
    add_entry(1'b0, SIZE_BYTE, 1'b1, 32'h30, 32'hffff_fff4, 32'h0, 32'h0000_0001);
    add_entry(1'b0, SIZE_HALF, 1'b1, 32'h20, 32'h3, 32'h0, 32'h0000_0123);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Driver and checks for one table entry
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_entry(input int i);
    entry_t     e;
    addr_t      eff;
    int         nbytes;
    int         first;
    int         n_gnt;
    int         waited;
    int         err0;
    logic [7:0] mask;
    logic       split;
    logic       got;
    e      = tbl[i];
    err0   = errors;
    eff    = e.op_a + e.op_b;
    nbytes = (e.size == SIZE_BYTE) ? 1 : (e.size == SIZE_HALF) ? 2 : 4;
    // Lanes of both words with the upper nibble in the next word
    mask   = 8'((1 << nbytes) - 1) << eff[1:0];
    split  = (mask[7:4] != 4'b0000);
    first  = grant_addr_q.size();
    valid_i     <= 1'b1;
    we_i        <= e.we;
    size_i      <= e.size;
    sext_i      <= e.sext;
    operand_a_i <= e.op_a;
    operand_b_i <= e.op_b;
    wdata_i     <= e.wdata;
    got    = 1'b0;
    waited = 0;
    while (!got && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
      if (result_valid_o) begin
        $display("Test %0d: result_valid_o pulsed before the last transfer", i);
        errors++;
      end
      got = ready_o;
    end
    valid_i <= 1'b0;
    if (!got) begin
      $display("Test %0d: ready_o never rose for the access", i);
      errors++;
    end else begin
      got    = 1'b0;
      waited = 0;
      while (!got && waited < WAIT_LIMIT) begin
        @(posedge clk);
        waited++;
        // Last transfer stays outstanding up to its response
        check("busy_o", 32'(busy_o), 32'd1);
        got = result_valid_o;
      end
      if (!got) begin
        $display("Test %0d: result_valid_o never pulsed after the last grant", i);
        errors++;
      end else if (!e.we) begin
        check("result_rdata_o", result_rdata_o, e.exp);
      end
    end
    // Bus side of each granted phase
    n_gnt = grant_addr_q.size() - first;
    check("grant count", 32'(n_gnt), split ? 32'd2 : 32'd1);
    if (n_gnt > 0) begin
      check("data_addr_o", grant_addr_q[first], eff);
      check("data_be_o", 32'(grant_be_q[first]), 32'(mask[3:0]));
    end
    if (split && n_gnt > 1) begin
      check("data_addr_o", grant_addr_q[first + 1], (eff & 32'hffff_fffc) + 32'd4);
      check("data_be_o", 32'(grant_be_q[first + 1]), 32'(mask[7:4]));
    end
    if (errors == err0) begin
      $display("Test %0d: %s %s at %h ok", i, e.we ? "store" : "load", e.size.name(), eff);
    end else begin
      failed_tests++;
      $display("Test %0d: %s %s at %h failed", i, e.we ? "store" : "load", e.size.name(), eff);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int idx;
    void'($urandom(32'h12fe_bf81));
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    data_rdata_i  = '0;
    cyc           = 0;
    gnt_wait      = 0;
    pulses        = 0;
    // Each byte holds its lane and word index
    for (int w = 0; w < 64; w++) begin
      mem[w] = {2'b11, 6'(w), 2'b10, 6'(w), 2'b01, 6'(w), 2'b00, 6'(w)};
    end
    forever begin
      @(posedge clk);
      if (!rst_n) begin
        data_gnt_i    <= 1'b0;
        data_rvalid_i <= 1'b0;
      end else begin
        if (result_valid_o) begin
          pulses++;
        end
        if (data_req_o && data_gnt_i) begin
          idx = int'(data_addr_o[7:2]);
          if (data_we_o) begin
            for (int b = 0; b < 4; b++) begin
              if (data_be_o[b]) begin
                mem[idx][b*8 +: 8] = data_wdata_o[b*8 +: 8];
              end
            end
          end
          // Reads return the full word and ignore the enables
          rsp_data_q.push_back(mem[idx]);
          rsp_due_q.push_back(cyc + int'($urandom_range(0, 2)));
          grant_addr_q.push_back(data_addr_o);
          grant_be_q.push_back(data_be_o);
          gnt_wait = int'($urandom_range(0, 2));
        end else if (gnt_wait > 0) begin
          gnt_wait--;
        end
        data_gnt_i <= (gnt_wait == 0);
        // Responses in order one to three cycles after the grant
        if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
          data_rvalid_i <= 1'b1;
          data_rdata_i  <= rsp_data_q.pop_front();
          void'(rsp_due_q.pop_front());
        end else begin
          data_rvalid_i <= 1'b0;
          data_rdata_i  <= $urandom();
        end
        cyc++;
      end
    end
  end

  // Watchdog allows 20 cycles per table entry
  initial begin
    repeat (NUM_TESTS * 20) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", NUM_TESTS * 20);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    valid_i      = 1'b0;
    we_i         = 1'b0;
    size_i       = SIZE_BYTE;
    sext_i       = 1'b0;
    operand_a_i  = '0;
    operand_b_i  = '0;
    wdata_i      = '0;
    errors       = 0;
    failed_tests = 0;
    n_entries    = 0;
    fill_table();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Idle outputs right after reset
    check("data_req_o", 32'(data_req_o), 32'd0);
    check("ready_o", 32'(ready_o), 32'd0);
    check("result_valid_o", 32'(result_valid_o), 32'd0);
    check("busy_o", 32'(busy_o), 32'd0);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_entry(i);
    end
    repeat (4) @(posedge clk);
    // Exactly one result pulse per access
    check("result_valid_o pulses", 32'(pulses), 32'(NUM_TESTS));
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: build.f
lsu_pkg.sv
lsu_addr_stage.sv
lsu_txn_tracker.sv
lsu_resp_stage.sv
lsu_top.sv
tb_lsu_assertions.sv
tb_lsu.sv

// File: run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_lsu \
  -f build.f --Mdir obj_dir -o tb_lsu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
